// File: line_tracker.f
+incdir+include
rtl/tracker_cfg_pkg.sv
rtl/tracker_sample_pkg.sv
rtl/memory_embedded.sv
rtl/tracker_config_decode.sv
rtl/tracker_sampler.sv
rtl/sample_buffer.sv
rtl/line_tracker_top.sv
sim/tb_line_tracker.sv

// File: run_sim.sh
#!/bin/sh
# build and run the line tracker testbench with Verilator
# exit status is nonzero unless the testbench reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f line_tracker.f \
	--top-module tb_line_tracker -o sim_line_tracker \
	&& ./obj_dir/sim_line_tracker | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& echo "run_sim: testbench reported a pass" \
	|| { echo "run_sim: build or simulation did not pass"; exit 1; }

// File: sim/tb_line_tracker.sv
`timescale 1ns/1ps

`include "line_tracker_macros.svh"

module tb_line_tracker
	import tracker_cfg_pkg::*;
	import tracker_sample_pkg::*;
();

	// ----------------------------------------
	// constants and stimulus table
	// ----------------------------------------

	localparam int FS         = 3;
	localparam int LIMIT      = `TRACKER_BUFFER_LIMIT;
	localparam int NUM_PHASES = 10;
	localparam int EN_LOW     = 0;
	localparam int EN_HIGH    = 1;
	localparam int EN_TOGGLE  = 2;

	// one row per phase
	// an expected field of -1 leaves that value unchecked
	typedef struct packed {
		int track;
		int clr;
		int en_mode;
		int req_pct;
		int cycles;
		int exp_count;
		int exp_stall;
		int readback;
	} phase_t;

	phase_t phases [NUM_PHASES] = '{
		'{1, 0, EN_TOGGLE, 60, 30, -1, 0, 0},
		'{1, 0, EN_HIGH, 100, 40, LIMIT, 1, 0},
		// further requests while full
		'{1, 0, EN_HIGH, 100, 10, LIMIT, 1, 0},
		'{1, 0, EN_LOW, 0, 0, LIMIT, 1, 1},
		// rising clear bit held for a few cycles
		'{1, 1, EN_LOW, 0, 3, 0, 0, 0},
		'{0, 0, EN_HIGH, 100, 10, 0, 0, 0},
		'{1, 0, EN_HIGH, 100, 40, LIMIT, 1, 0},
		'{1, 0, EN_LOW, 0, 0, LIMIT, 1, 1},
		'{0, 0, EN_HIGH, 100, 20, LIMIT, 1, 0},
		'{0, 0, EN_LOW, 0, 0, LIMIT, 1, 1}
	};

	// ----------------------------------------
	// DUT and clock
	// ----------------------------------------

	logic         clock_i;
	logic         resetn_i;
	config_word_t config_i;
	logic         request_i;
	logic         en_i;
	expired_set_t expired_bits_i;
	logic         stall_o;
	fill_count_t  count_o;
	trace_count_t trace_o;
	expired_set_t expired_bits_o;

	line_tracker_top #(
		.FS (FS)
	) i_dut (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.config_i       (config_i),
		.request_i      (request_i),
		.en_i           (en_i),
		.expired_bits_i (expired_bits_i),
		.stall_o        (stall_o),
		.count_o        (count_o),
		.trace_o        (trace_o),
		.expired_bits_o (expired_bits_o)
	);

	always #10 clock_i = ~clock_i;

	// ----------------------------------------
	// reference model state
	// ----------------------------------------

	// model copies of the decoded host word as the tracker sees it
	logic        m_track;
	logic        m_clear;
	logic        m_clr_prev;
	logic        m_stall;
	int          m_acc;
	sample_rec_t m_recs [$];

	int pass_count  = 0;
	int fail_count  = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	// end the run once the cycle limit is reached
	always @(posedge clock_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
			input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	// sampling rule applied to the inputs the DUT saw at this edge
	task automatic update_model();
		sample_rec_t rec;
		if (m_clear) begin
			m_acc   = 0;
			m_stall = 1'b0;
			m_recs.delete();
		end else if (m_track && en_i && request_i && !m_stall) begin
			m_acc++;
			if (m_acc % FS == 0) begin
				rec.expired = expired_bits_i;
				rec.trace   = trace_count_t'(m_acc);
				m_recs.push_back(rec);
				m_stall = (m_recs.size() == LIMIT);
			end
		end
		// clear pulse follows a rising clear bit by one register stage
		m_clear    = config_i.clear && !m_clr_prev;
		m_clr_prev = config_i.clear;
		m_track    = config_i.track;
	endtask

	// outputs are sampled and inputs driven 2 ns after the edge
	task automatic step_cycle();
		@(posedge clock_i);
		update_model();
		#2;
	endtask

	task automatic drive_inputs(input phase_t row, input int idx, input int addr);
		config_word_t cfg;
		cfg                 = '0;
		cfg.track           = row.track[0];
		cfg.clear           = row.clr[0];
		cfg.host_addr_field = 18'(addr);
		config_i            = cfg;
		en_i                = (row.en_mode == EN_HIGH) ||
			(row.en_mode == EN_TOGGLE && idx % 2 == 0);
		request_i           = ($urandom % 100) < row.req_pct;
		expired_bits_i.way0 = line_mask_t'($urandom);
		expired_bits_i.way1 = line_mask_t'($urandom);
		expired_bits_i.way2 = line_mask_t'($urandom);
	endtask

	task automatic run_readback(input phase_t row);
		for (int a = 0; a < LIMIT; a++) begin
			drive_inputs(row, 0, a);
			// one cycle for the address register and one for the ram output
			step_cycle();
			step_cycle();
			if (a < m_recs.size()) begin
				check_value(trace_o, m_recs[a].trace, $sformatf("trace_o at address %0d", a));
				check_value(128'(expired_bits_o), 128'(m_recs[a].expired),
					$sformatf("expired_bits_o at address %0d", a));
			end else begin
				$display("readback of address %0d has no record in the model", a);
				fail_count++;
			end
		end
	endtask

	task automatic check_phase_end(input phase_t row);
		check_value(128'(count_o), 128'(m_acc / FS), "count_o against accepted accesses");
		check_value(128'(stall_o), 128'(m_stall), "stall_o against model");
		if (row.exp_count >= 0) begin
			check_value(128'(count_o), 128'(row.exp_count), "count_o against table");
		end
		if (row.exp_stall >= 0) begin
			check_value(128'(stall_o), 128'(row.exp_stall), "stall_o against table");
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		phase_t      row;
		int          errors_before;
		clock_i        = 1'b0;
		resetn_i       = 1'b0;
		config_i       = '0;
		request_i      = 1'b0;
		en_i           = 1'b0;
		expired_bits_i = '0;
		m_track        = 1'b0;
		m_clear        = 1'b0;
		m_clr_prev     = 1'b0;
		m_stall        = 1'b0;
		m_acc          = 0;
		void'($urandom(32'h60c188fe));
		cycle_limit    = 4 + 100;
		for (int p = 0; p < NUM_PHASES; p++) begin
			cycle_limit += phases[p].cycles + ((phases[p].readback != 0) ? 2 * LIMIT : 0);
		end
		repeat (4) @(posedge clock_i);
		#2;
		resetn_i = 1'b1;
		// counters and read outputs come out of reset at zero
		errors_before = fail_count;
		check_value(128'(count_o), 128'(0), "count_o after reset");
		check_value(128'(stall_o), 128'(0), "stall_o after reset");
		check_value(trace_o, 128'(0), "trace_o after reset");
		check_value(128'(expired_bits_o), 128'(0), "expired_bits_o after reset");
		$display("reset %s, %0d errors", (fail_count == errors_before) ? "ok" : "bad",
			fail_count - errors_before);
		for (int p = 0; p < NUM_PHASES; p++) begin
			row           = phases[p];
			errors_before = fail_count;
			if (row.readback != 0) begin
				run_readback(row);
			end else begin
				for (int i = 0; i < row.cycles; i++) begin
					drive_inputs(row, i, 0);
					step_cycle();
				end
			end
			check_phase_end(row);
			$display("phase %0d %s, %0d errors, count %0d, stall %0b", p,
				(fail_count == errors_before) ? "ok" : "bad",
				fail_count - errors_before, count_o, stall_o);
		end
		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: rtl/line_tracker_top.sv
`timescale 1ns/1ps

`include "line_tracker_macros.svh"

module line_tracker_top
	import tracker_cfg_pkg::*;
	import tracker_sample_pkg::*;
#(
	parameter int FS = `TRACKER_FS_DEFAULT
) (
	input  logic         clock_i,
	input  logic         resetn_i,
	input  config_word_t config_i,
	input  logic         request_i,
	input  logic         en_i,
	input  expired_set_t expired_bits_i,
	output logic         stall_o,
	output fill_count_t  count_o,
	output trace_count_t trace_o,
	output expired_set_t expired_bits_o
);

	// ----------------------------------------
	// internal wiring
	// ----------------------------------------

	tracker_ctrl_t ctrl;
	logic          wr;
	buf_addr_t     wr_addr;
	sample_rec_t   wr_rec;
	sample_rec_t   rd_rec;

	// decode, registers the host word
	tracker_config_decode i_decode (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.config_i (config_i),
		.ctrl_o   (ctrl)
	);

	// execute, counting and sampling
	tracker_sampler #(
		.FS (FS)
	) i_sampler (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.ctrl_i         (ctrl),
		.request_i      (request_i),
		.en_i           (en_i),
		.expired_bits_i (expired_bits_i),
		.wr_o           (wr),
		.wr_addr_o      (wr_addr),
		.wr_rec_o       (wr_rec),
		.count_o        (count_o),
		.stall_o        (stall_o)
	);

	// result, buffer memory and host readout
	sample_buffer i_buffer (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.ctrl_i    (ctrl),
		.stall_i   (stall_o),
		.wr_i      (wr),
		.wr_addr_i (wr_addr),
		.wr_rec_i  (wr_rec),
		.rd_rec_o  (rd_rec)
	);

	assign trace_o        = rd_rec.trace;
	assign expired_bits_o = rd_rec.expired;

endmodule

// File: rtl/sample_buffer.sv
`timescale 1ns/1ps

`include "line_tracker_macros.svh"

module sample_buffer
	import tracker_cfg_pkg::*;
	import tracker_sample_pkg::*;
(
	input  logic          clock_i,
	input  logic          resetn_i,
	input  tracker_ctrl_t ctrl_i,
	input  logic          stall_i,
	input  logic          wr_i,
	input  buf_addr_t     wr_addr_i,
	input  sample_rec_t   wr_rec_i,
	output sample_rec_t   rd_rec_o
);

	// ----------------------------------------
	// port arbitration
	// ----------------------------------------

	logic      sampler_port;
	logic      mem_wren;
	buf_addr_t mem_addr;

	// sampler keeps the port while tracking and not full
	// a pending write still gets it, so the last record lands before the host reads
	assign sampler_port = ctrl_i.tracking & (~stall_i | wr_i);
	assign mem_addr     = sampler_port ? wr_addr_i : ctrl_i.host_addr;
	assign mem_wren     = sampler_port & wr_i;

	// ----------------------------------------
	// entry valid tracking
	// ----------------------------------------

	// entries never written read back as zero
	logic [`TRACKER_BUFFER_LIMIT-1:0] valid_q;
	logic                             rd_valid_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q    <= '0;
			rd_valid_q <= 1'b0;
		end else begin
			if (mem_wren) begin
				valid_q[mem_addr] <= 1'b1;
			end
			// aligned with the registered ram output
			rd_valid_q <= valid_q[mem_addr];
		end
	end

	// ----------------------------------------
	// memory banks
	// ----------------------------------------

	sample_rec_t rd_data;

	memory_embedded #(
		.N_ENTRIES (`TRACKER_BUFFER_LIMIT),
		.BW_DATA   ($bits(line_mask_t))
	) i_mem_way0 (
		.clock_i (clock_i),
		.wren_i  (mem_wren),
		.addr_i  (mem_addr),
		.data_i  (wr_rec_i.expired.way0),
		.data_o  (rd_data.expired.way0)
	);

	memory_embedded #(
		.N_ENTRIES (`TRACKER_BUFFER_LIMIT),
		.BW_DATA   ($bits(line_mask_t))
	) i_mem_way1 (
		.clock_i (clock_i),
		.wren_i  (mem_wren),
		.addr_i  (mem_addr),
		.data_i  (wr_rec_i.expired.way1),
		.data_o  (rd_data.expired.way1)
	);

	memory_embedded #(
		.N_ENTRIES (`TRACKER_BUFFER_LIMIT),
		.BW_DATA   ($bits(line_mask_t))
	) i_mem_way2 (
		.clock_i (clock_i),
		.wren_i  (mem_wren),
		.addr_i  (mem_addr),
		.data_i  (wr_rec_i.expired.way2),
		.data_o  (rd_data.expired.way2)
	);

	// trace bank is the wide one
	memory_embedded #(
		.N_ENTRIES (`TRACKER_BUFFER_LIMIT),
		.BW_DATA   ($bits(trace_count_t))
	) i_mem_trace (
		.clock_i (clock_i),
		.wren_i  (mem_wren),
		.addr_i  (mem_addr),
		.data_i  (wr_rec_i.trace),
		.data_o  (rd_data.trace)
	);

	assign rd_rec_o = rd_valid_q ? rd_data : '0;

endmodule

// File: rtl/tracker_sampler.sv
`timescale 1ns/1ps

`include "line_tracker_macros.svh"

module tracker_sampler
	import tracker_cfg_pkg::*;
	import tracker_sample_pkg::*;
#(
	parameter int FS = `TRACKER_FS_DEFAULT
) (
	input  logic          clock_i,
	input  logic          resetn_i,
	input  tracker_ctrl_t ctrl_i,
	input  logic          request_i,
	input  logic          en_i,
	input  expired_set_t  expired_bits_i,
	output logic          wr_o,
	output buf_addr_t     wr_addr_o,
	output sample_rec_t   wr_rec_o,
	output fill_count_t   count_o,
	output logic          stall_o
);

	// ----------------------------------------
	// constants
	// ----------------------------------------

	// period counter width, at least one bit so FS of 1 still builds
	localparam int BW_PERIOD = (FS > 1) ? $clog2(FS) : 1;
	localparam logic [BW_PERIOD-1:0] PERIOD_LAST = BW_PERIOD'(FS - 1);
	localparam fill_count_t FILL_FULL = fill_count_t'(`TRACKER_BUFFER_LIMIT);

	// ----------------------------------------
	// state
	// ----------------------------------------

	logic [BW_PERIOD-1:0] period_q;
	trace_count_t         trace_q;
	fill_count_t          count_q;
	logic                 stall_q;
	logic                 wr_q;

	// record and address staged for the buffer
	buf_addr_t            wr_addr_q;
	sample_rec_t          wr_rec_q;

	// ----------------------------------------
	// access qualification
	// ----------------------------------------

	logic         accept;
	logic         sample;
	trace_count_t trace_next;
	fill_count_t  count_next;

	// an access counts only while tracking, enabled and not held off
	assign accept     = ctrl_i.tracking & en_i & request_i & ~stall_q;
	// last access of the current period gets sampled
	assign sample     = accept & (period_q == PERIOD_LAST);
	// the stored count includes the access being sampled
	assign trace_next = trace_q + 1'b1;
	assign count_next = count_q + 1'b1;

	// control state
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			period_q <= '0;
			trace_q  <= '0;
			count_q  <= '0;
			stall_q  <= 1'b0;
			wr_q     <= 1'b0;
		end else if (ctrl_i.clear) begin
			// clear wins over a sample on the same edge
			period_q <= '0;
			trace_q  <= '0;
			count_q  <= '0;
			stall_q  <= 1'b0;
			wr_q     <= 1'b0;
		end else begin
			wr_q <= sample;
			if (accept) begin
				trace_q  <= trace_next;
				period_q <= sample ? '0 : period_q + 1'b1;
			end
			if (sample) begin
				count_q <= count_next;
				// hold the cache controller once the last slot is taken
				stall_q <= (count_next == FILL_FULL);
			end
		end
	end

	// payload, only loaded when a sample is taken
	always_ff @(posedge clock_i) begin
		if (sample) begin
			wr_addr_q        <= count_q[`TRACKER_BW_ADDR-1:0];
			wr_rec_q.expired <= expired_bits_i;
			wr_rec_q.trace   <= trace_next;
		end
	end

	// ----------------------------------------
	// outputs
	// ----------------------------------------

	assign wr_o      = wr_q;
	assign wr_addr_o = wr_addr_q;
	assign wr_rec_o  = wr_rec_q;
	assign count_o   = count_q;
	assign stall_o   = stall_q;

endmodule

// File: rtl/tracker_config_decode.sv
`timescale 1ns/1ps

`include "line_tracker_macros.svh"

module tracker_config_decode
	import tracker_cfg_pkg::*;
(
	input  logic          clock_i,
	input  logic          resetn_i,
	input  config_word_t  config_i,
	output tracker_ctrl_t ctrl_o
);

	// ----------------------------------------
	// config register
	// ----------------------------------------

	// registered copy of the host word, also serves as the previous value
	// of the clear bit for edge detection
	config_word_t cfg_q;

	// single-cycle clear, high the cycle after the clear bit rose
	logic clear_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			cfg_q   <= '0;
			clear_q <= 1'b0;
		end else begin
			cfg_q   <= config_i;
			// rising edge only, so a held clear bit does not keep wiping records
			clear_q <= config_i.clear & ~cfg_q.clear;
		end
	end

	// ----------------------------------------
	// decoded control
	// ----------------------------------------

	assign ctrl_o.tracking  = cfg_q.track;
	assign ctrl_o.clear     = clear_q;
	// host address starts at bit 5 of the word, buffer decodes only the low bits
	assign ctrl_o.host_addr = cfg_q.host_addr_field[`TRACKER_BW_ADDR-1:0];

endmodule

// File: rtl/memory_embedded.sv
`timescale 1ns/1ps

module memory_embedded #(
	parameter int N_ENTRIES = 8,
	parameter int BW_DATA   = 16
) (
	input  logic                         clock_i,
	input  logic                         wren_i,
	input  logic [$clog2(N_ENTRIES)-1:0] addr_i,
	input  logic [BW_DATA-1:0]           data_i,
	output logic [BW_DATA-1:0]           data_o
);

	// ----------------------------------------
	// storage
	// ----------------------------------------

	logic [BW_DATA-1:0] mem [N_ENTRIES];
	logic [BW_DATA-1:0] rd_q;

	// single port, write when enabled
	// read data registered every cycle, old contents on a write
	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			mem[addr_i] <= data_i;
		end
		rd_q <= mem[addr_i];
	end

	assign data_o = rd_q;

endmodule

// File: rtl/tracker_sample_pkg.sv
`include "line_tracker_macros.svh"

package tracker_sample_pkg;

	// ----------------------------------------
	// sampled payload
	// ----------------------------------------

	// one bit per cache line whose eviction bit has expired
	typedef logic [`TRACKER_N_LINES-1:0] line_mask_t;

	// masks from the three ways of the cache
	typedef struct packed {
		line_mask_t way0;
		line_mask_t way1;
		line_mask_t way2;
	} expired_set_t;

	// running count of accepted accesses, wide enough never to wrap in practice
	typedef logic [127:0] trace_count_t;

	// ----------------------------------------
	// buffer bookkeeping
	// ----------------------------------------

	typedef logic [`TRACKER_BW_ADDR-1:0] buf_addr_t;

	// fill level as the host sees it
	typedef logic [31:0] fill_count_t;

	// one buffer entry
	typedef struct packed {
		expired_set_t expired;
		trace_count_t trace;
	} sample_rec_t;

endpackage

// File: rtl/tracker_cfg_pkg.sv
`include "line_tracker_macros.svh"

package tracker_cfg_pkg;

	// ----------------------------------------
	// host configuration word
	// ----------------------------------------

	// field layout of the 32-bit word written by the host
	// bit 24 tracking enable, bit 23 buffer clear, bits 22:5 host read address
	typedef struct packed {
		logic [6:0]  rsvd_hi;
		logic        track;
		logic        clear;
		logic [17:0] host_addr_field;
		logic [4:0]  rsvd_lo;
	} config_word_t;

	// ----------------------------------------
	// decoded control
	// ----------------------------------------

	// tracking is a level, clear lasts a single cycle
	// host_addr only has the bits the buffer decodes
	typedef struct packed {
		logic                        tracking;
		logic                        clear;
		logic [`TRACKER_BW_ADDR-1:0] host_addr;
	} tracker_ctrl_t;

endpackage

// File: include/line_tracker_macros.svh
`ifndef LINE_TRACKER_MACROS_SVH
`define LINE_TRACKER_MACROS_SVH

// ----------------------------------------
// buffer geometry
// ----------------------------------------

// number of sample records held on chip
`define TRACKER_BUFFER_LIMIT 8

// log2 of the buffer limit, width of a buffer address
`define TRACKER_BW_ADDR 3

// ----------------------------------------
// cache geometry and sampling
// ----------------------------------------

// cache lines covered by one expired mask
`define TRACKER_N_LINES 16

// every n-th accepted access is sampled
`define TRACKER_FS_DEFAULT 3

`endif
